/* design/usb_xact_pkg.sv */
package usb_xact_pkg;

  // Field widths
  localparam int ADDR_W = 7;
  localparam int ENDP_W = 4;
  localparam int BYTE_W = 8;
  localparam int TUSER_W = 4;

  // Token type, as decoded from the token PID
  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_SOF   = 2'b01,
    TOK_IN    = 2'b10,
    TOK_SETUP = 2'b11
  } token_pid_e;

  // Handshake type, upper half of the PID field
  typedef enum logic [1:0] {
    HSK_ACK = 2'b00,
    HSK_NAK = 2'b10
  } hsk_pid_e;

  // Data packet type, upper half of the PID field
  typedef enum logic [1:0] {
    DATA0 = 2'b00,
    DATA1 = 2'b10
  } data_pid_e;

  // Packet class, lower half of the PID field
  typedef enum logic [1:0] {
    CLS_HSK  = 2'b10,
    CLS_DATA = 2'b11
  } pid_class_e;

  typedef enum logic {
    XS_IDLE,
    XS_BULK
  } xact_state_e;

  typedef enum logic [2:0] {
    BLK_IDLE,
    BLK_IN_TX,
    BLK_IN_ZDP,
    BLK_IN_ACK,
    BLK_OUT_RX,
    BLK_OUT_DROP,
    BLK_OUT_HSK,
    BLK_DONE
  } bulk_state_e;

  // Last error seen on an addressed token
  typedef enum logic [2:0] {
    ER_NONE = 3'h0,
    ER_TOKN = 3'h3,
    ER_ENDP = 3'h5
  } err_code_e;

endpackage

/* design/usb_token_if.sv */
interface usb_token_if;

  // Token strobe, fields valid only while it is high
  logic recv;
  logic ping;
  logic [usb_xact_pkg::ADDR_W-1:0] addr;
  logic [usb_xact_pkg::ENDP_W-1:0] endp;
  usb_xact_pkg::token_pid_e pid;

  // Driven from the decoder side
  modport source(
    output recv,
    output ping,
    output addr,
    output endp,
    output pid
  );

  // Modules that react to tokens
  modport sink(
    input recv,
    input ping,
    input addr,
    input endp,
    input pid
  );

endinterface

/* design/xact_dispatch.sv */
module xact_dispatch #(
  parameter int ENDPOINT1 = 1,
  parameter int ENDPOINT2 = 2
) (
  input  logic clock,
  input  logic reset,
  input  logic [usb_xact_pkg::ADDR_W-1:0] usb_addr_i,
  usb_token_if.sink tok,
  input  logic bulk_done_i,
  output logic bulk_active_o,
  output logic [usb_xact_pkg::ENDP_W-1:0] endp_sel_o,
  output logic token_in_o,
  output usb_xact_pkg::err_code_e err_code_o
);

  localparam logic [usb_xact_pkg::ENDP_W-1:0] EP1 = ENDPOINT1[usb_xact_pkg::ENDP_W-1:0];
  localparam logic [usb_xact_pkg::ENDP_W-1:0] EP2 = ENDPOINT2[usb_xact_pkg::ENDP_W-1:0];

  usb_xact_pkg::xact_state_e state_q;
  usb_xact_pkg::err_code_e err_q;
  logic [usb_xact_pkg::ENDP_W-1:0] endp_q;
  logic token_in_q;
  logic addressed;
  logic bulk_tok;
  logic endp_ok;
  logic accept;

  // Only tokens for this device are looked at
  assign addressed = tok.recv && tok.addr == usb_addr_i;

  // IN, OUT and PING are bulk tokens, SETUP and SOF are not handled
  assign bulk_tok = tok.ping || tok.pid == usb_xact_pkg::TOK_IN ||
                    tok.pid == usb_xact_pkg::TOK_OUT;
  assign endp_ok = tok.endp == EP1 || tok.endp == EP2;
  assign accept = state_q == usb_xact_pkg::XS_IDLE && addressed && bulk_tok && endp_ok;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= usb_xact_pkg::XS_IDLE;
      err_q <= usb_xact_pkg::ER_NONE;
    end else begin
      case (state_q)
        usb_xact_pkg::XS_IDLE: begin
          // Error code sticks until the next addressed token
          if (addressed) begin
            if (!bulk_tok) begin
              err_q <= usb_xact_pkg::ER_TOKN;
            end else if (!endp_ok) begin
              err_q <= usb_xact_pkg::ER_ENDP;
            end else begin
              err_q <= usb_xact_pkg::ER_NONE;
              state_q <= usb_xact_pkg::XS_BULK;
            end
          end
        end
        usb_xact_pkg::XS_BULK: begin
          // Bulk sequencer has finished the transaction
          if (bulk_done_i) begin
            state_q <= usb_xact_pkg::XS_IDLE;
          end
        end
      endcase
    end
  end

  // Endpoint and direction of the accepted token
  always_ff @(posedge clock) begin
    if (accept) begin
      endp_q <= tok.endp;
      token_in_q <= tok.pid == usb_xact_pkg::TOK_IN && !tok.ping;
    end
  end

  assign bulk_active_o = state_q == usb_xact_pkg::XS_BULK;
  assign endp_sel_o = endp_q;
  assign token_in_o = token_in_q;
  assign err_code_o = err_q;

endmodule

/* design/bulk_xact_fsm.sv */
module bulk_xact_fsm (
  input  logic clock,
  input  logic reset,
  input  logic bulk_active_i,
  input  logic token_in_i,
  input  logic blk_in_ready_i,
  input  logic blk_out_ready_i,
  input  logic usb_sent_i,
  input  logic hsk_recv_i,
  input  usb_xact_pkg::hsk_pid_e hsk_pid_i,
  input  logic hsk_sent_i,
  input  logic timeout_i,
  // User source, IN data
  input  logic blk_tvalid_i,
  output logic blk_tready_o,
  input  logic blk_tlast_i,
  input  logic blk_tkeep_i,
  input  logic [usb_xact_pkg::BYTE_W-1:0] blk_tdata_i,
  // To the packet encoder
  output logic usb_tvalid_o,
  input  logic usb_tready_i,
  output logic usb_tlast_o,
  output logic usb_tkeep_o,
  output logic [usb_xact_pkg::BYTE_W-1:0] usb_tdata_o,
  // From the packet decoder, OUT data
  input  logic usb_tvalid_i,
  output logic usb_tready_o,
  input  logic usb_tlast_i,
  input  logic [usb_xact_pkg::BYTE_W-1:0] usb_tdata_i,
  // User sink
  output logic blk_tvalid_o,
  input  logic blk_tready_i,
  output logic blk_tlast_o,
  output logic [usb_xact_pkg::BYTE_W-1:0] blk_tdata_o,
  output logic blk_start_o,
  output logic bulk_done_o,
  output logic toggle_o,
  output logic nak_o,
  output logic hsk_wait_o
);

  usb_xact_pkg::bulk_state_e state_q;
  logic nak_q;
  logic tx_open_q;
  logic sel_tx;
  logic sel_zdp;
  logic tx_beat;
  logic rx_beat;

  // Transmit window closes after the tlast beat
  assign sel_tx = state_q == usb_xact_pkg::BLK_IN_TX && tx_open_q;
  assign sel_zdp = state_q == usb_xact_pkg::BLK_IN_ZDP && tx_open_q;
  assign tx_beat = usb_tvalid_o && usb_tready_i;
  assign rx_beat = usb_tvalid_i && usb_tready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= usb_xact_pkg::BLK_IDLE;
      nak_q <= 1'b0;
      tx_open_q <= 1'b0;
    end else begin
      case (state_q)
        usb_xact_pkg::BLK_IDLE: begin
          if (bulk_active_i) begin
            // Direction and readiness pick the path
            nak_q <= !token_in_i && !blk_out_ready_i;
            tx_open_q <= token_in_i;
            if (token_in_i) begin
              state_q <= blk_in_ready_i ? usb_xact_pkg::BLK_IN_TX : usb_xact_pkg::BLK_IN_ZDP;
            end else begin
              state_q <= blk_out_ready_i ? usb_xact_pkg::BLK_OUT_RX : usb_xact_pkg::BLK_OUT_DROP;
            end
          end
        end
        usb_xact_pkg::BLK_IN_TX, usb_xact_pkg::BLK_IN_ZDP: begin
          if (tx_beat && usb_tlast_o) begin
            tx_open_q <= 1'b0;
          end
          if (usb_sent_i) begin
            state_q <= usb_xact_pkg::BLK_IN_ACK;
          end
        end
        // Host answers, or goes silent
        usb_xact_pkg::BLK_IN_ACK: begin
          if (hsk_recv_i || timeout_i) begin
            state_q <= usb_xact_pkg::BLK_DONE;
          end
        end
        usb_xact_pkg::BLK_OUT_RX, usb_xact_pkg::BLK_OUT_DROP: begin
          if (rx_beat && usb_tlast_i) begin
            state_q <= usb_xact_pkg::BLK_OUT_HSK;
          end else if (timeout_i) begin
            state_q <= usb_xact_pkg::BLK_DONE;
          end
        end
        usb_xact_pkg::BLK_OUT_HSK: begin
          if (hsk_sent_i) begin
            state_q <= usb_xact_pkg::BLK_DONE;
          end
        end
        usb_xact_pkg::BLK_DONE: begin
          state_q <= usb_xact_pkg::BLK_IDLE;
        end
      endcase
    end
  end

  // IN path, source straight to encoder, or one empty tlast beat
  assign usb_tvalid_o = sel_tx ? blk_tvalid_i : sel_zdp;
  assign usb_tlast_o = sel_tx ? blk_tlast_i : 1'b1;
  assign usb_tkeep_o = sel_tx ? blk_tkeep_i : 1'b0;
  assign usb_tdata_o = sel_tx ? blk_tdata_i : '0;
  assign blk_tready_o = sel_tx && usb_tready_i;

  // OUT path, data is swallowed outside BLK_OUT_RX
  assign blk_tvalid_o = state_q == usb_xact_pkg::BLK_OUT_RX && usb_tvalid_i;
  assign blk_tlast_o = usb_tlast_i;
  assign blk_tdata_o = usb_tdata_i;
  assign usb_tready_o = state_q == usb_xact_pkg::BLK_OUT_RX ? blk_tready_i : 1'b1;

  assign blk_start_o = bulk_active_i && state_q == usb_xact_pkg::BLK_IDLE;
  assign bulk_done_o = state_q == usb_xact_pkg::BLK_DONE;

  // Toggle advances only on a completed, acknowledged packet
  assign toggle_o = (state_q == usb_xact_pkg::BLK_IN_ACK && hsk_recv_i &&
                     hsk_pid_i == usb_xact_pkg::HSK_ACK) ||
                    (state_q == usb_xact_pkg::BLK_OUT_HSK && hsk_sent_i && !nak_q);
  assign nak_o = nak_q;
  assign hsk_wait_o = state_q == usb_xact_pkg::BLK_OUT_HSK;

endmodule

/* design/data_toggle.sv */
module data_toggle #(
  parameter int NUM_ENDP = 16
) (
  input  logic clock,
  input  logic reset,
  usb_token_if.sink tok,
  input  logic [usb_xact_pkg::ENDP_W-1:0] endp_sel_i,
  input  logic toggle_i,
  input  logic nak_i,
  input  logic hsk_req_i,
  output logic [usb_xact_pkg::TUSER_W-1:0] usb_tuser_o
);

  // One DATA0/DATA1 bit per endpoint, high means DATA1
  logic [NUM_ENDP-1:0] odd_q;
  logic [usb_xact_pkg::TUSER_W-1:0] tuser_q;
  logic tok_odd;

  assign tok_odd = odd_q[tok.endp];

  always_ff @(posedge clock) begin
    if (reset) begin
      odd_q <= '0;
    end else if (toggle_i) begin
      odd_q[endp_sel_i] <= ~odd_q[endp_sel_i];
    end
  end

  // PID field for the encoder
  // Handshake request wins over a token in the same cycle
  always_ff @(posedge clock) begin
    if (hsk_req_i) begin
      tuser_q <= {nak_i ? usb_xact_pkg::HSK_NAK : usb_xact_pkg::HSK_ACK,
                  usb_xact_pkg::CLS_HSK};
    end else if (tok.recv && tok.pid == usb_xact_pkg::TOK_IN) begin
      tuser_q <= {tok_odd ? usb_xact_pkg::DATA1 : usb_xact_pkg::DATA0,
                  usb_xact_pkg::CLS_DATA};
    end
  end

  assign usb_tuser_o = tuser_q;

endmodule

/* design/eop_handshake.sv */
module eop_handshake #(
  parameter int EOP_DELAY = 5
) (
  input  logic clock,
  input  logic reset,
  input  logic usb_recv_i,
  input  logic usb_tvalid_i,
  // Receive ready, as driven back to the decoder
  input  logic usb_tready_o,
  input  logic hsk_wait_i,
  input  logic hsk_sent_i,
  output logic hsk_send_o,
  output logic hsk_req_o,
  output logic rx_event_o
);

  localparam int CNT_W = $clog2(EOP_DELAY + 1);

  logic [CNT_W-1:0] eop_cnt_q;
  logic hsk_send_q;
  logic rx_beat;
  logic eop;

  assign rx_beat = usb_tvalid_i && usb_tready_o;

  // Bus considered quiet once the count runs out
  assign eop = eop_cnt_q == CNT_W'(1);

  always_ff @(posedge clock) begin
    if (reset) begin
      eop_cnt_q <= '0;
    end else if (usb_recv_i || rx_beat) begin
      eop_cnt_q <= CNT_W'(EOP_DELAY);
    end else if (eop_cnt_q != '0) begin
      eop_cnt_q <= eop_cnt_q - 1'b1;
    end
  end

  // One request per packet end
  assign hsk_req_o = eop && hsk_wait_i && !hsk_send_q;

  // Held until the encoder reports the handshake sent
  always_ff @(posedge clock) begin
    if (reset || hsk_sent_i) begin
      hsk_send_q <= 1'b0;
    end else if (hsk_req_o) begin
      hsk_send_q <= 1'b1;
    end
  end

  assign hsk_send_o = hsk_send_q;
  assign rx_event_o = usb_recv_i;

endmodule

/* design/turnaround_timer.sv */
module turnaround_timer #(
  parameter int TURNAROUND = 255
) (
  input  logic clock,
  input  logic reset,
  usb_token_if.sink tok,
  input  logic usb_sent_i,
  input  logic rx_event_i,
  input  logic hsk_recv_i,
  output logic timeout_o,
  output logic usb_timeout_error_o
);

  localparam int CNT_W = $clog2(TURNAROUND + 1);

  logic [CNT_W-1:0] count_q;
  logic active_q;
  logic err_q;
  logic start;
  logic rx_any;
  logic stop;

  // Waiting on the host after our data, or after an OUT token
  assign start = usb_sent_i || (tok.recv && tok.pid == usb_xact_pkg::TOK_OUT);
  assign rx_any = rx_event_i || hsk_recv_i;
  assign stop = rx_any || tok.recv;

  // Last cycle of the window
  assign timeout_o = active_q && count_q == CNT_W'(1);

  always_ff @(posedge clock) begin
    if (reset) begin
      active_q <= 1'b0;
      err_q <= 1'b0;
    end else if (start) begin
      count_q <= CNT_W'(TURNAROUND);
      active_q <= 1'b1;
      err_q <= 1'b0;
    end else if (stop) begin
      active_q <= 1'b0;
      if (rx_any) begin
        err_q <= 1'b0;
      end
    end else if (timeout_o) begin
      active_q <= 1'b0;
      err_q <= 1'b1;
    end else if (active_q) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign usb_timeout_error_o = err_q;

endmodule

/* design/usb_bulk_xact.sv */
module usb_bulk_xact #(
  parameter int ENDPOINT1 = 1,
  parameter int ENDPOINT2 = 2,
  parameter int NUM_ENDP = 16,
  parameter int EOP_DELAY = 5,
  parameter int TURNAROUND = 255
) (
  input  logic clock,
  input  logic reset,
  input  logic [usb_xact_pkg::ADDR_W-1:0] usb_addr_i,
  output logic usb_timeout_error_o,
  output logic usb_device_idle_o,
  output usb_xact_pkg::err_code_e err_code_o,
  // Bulk control
  input  logic blk_in_ready_i,
  input  logic blk_out_ready_i,
  output logic blk_start_o,
  output logic blk_cycle_o,
  output logic [usb_xact_pkg::ENDP_W-1:0] blk_endpt_o,
  // User sink
  output logic blk_tvalid_o,
  input  logic blk_tready_i,
  output logic blk_tlast_o,
  output logic [usb_xact_pkg::BYTE_W-1:0] blk_tdata_o,
  // User source
  input  logic blk_tvalid_i,
  output logic blk_tready_o,
  input  logic blk_tlast_i,
  input  logic blk_tkeep_i,
  input  logic [usb_xact_pkg::BYTE_W-1:0] blk_tdata_i,
  // Decoder events
  input  logic tok_recv_i,
  input  logic tok_ping_i,
  input  logic [usb_xact_pkg::ADDR_W-1:0] tok_addr_i,
  input  logic [usb_xact_pkg::ENDP_W-1:0] tok_endp_i,
  input  usb_xact_pkg::token_pid_e tok_pid_i,
  input  logic hsk_recv_i,
  input  usb_xact_pkg::hsk_pid_e hsk_pid_i,
  output logic hsk_send_o,
  input  logic hsk_sent_i,
  input  logic usb_recv_i,
  input  logic usb_sent_i,
  // Received data
  input  logic usb_tvalid_i,
  output logic usb_tready_o,
  input  logic usb_tlast_i,
  input  logic [usb_xact_pkg::BYTE_W-1:0] usb_tdata_i,
  // To the encoder
  output logic usb_tvalid_o,
  input  logic usb_tready_i,
  output logic usb_tkeep_o,
  output logic usb_tlast_o,
  output logic [usb_xact_pkg::TUSER_W-1:0] usb_tuser_o,
  output logic [usb_xact_pkg::BYTE_W-1:0] usb_tdata_o
);

  logic bulk_active;
  logic [usb_xact_pkg::ENDP_W-1:0] endp_sel;
  logic token_in;
  logic bulk_done;
  logic toggle;
  logic nak;
  logic hsk_wait;
  logic hsk_req;
  logic rx_event;
  logic timeout;

  usb_token_if tok_if ();

  assign tok_if.recv = tok_recv_i;
  assign tok_if.ping = tok_ping_i;
  assign tok_if.addr = tok_addr_i;
  assign tok_if.endp = tok_endp_i;
  assign tok_if.pid = tok_pid_i;

  xact_dispatch #(
    .ENDPOINT1(ENDPOINT1),
    .ENDPOINT2(ENDPOINT2)
  ) u_dispatch (
    .clock(clock),
    .reset(reset),
    .usb_addr_i(usb_addr_i),
    .tok(tok_if.sink),
    .bulk_done_i(bulk_done),
    .bulk_active_o(bulk_active),
    .endp_sel_o(endp_sel),
    .token_in_o(token_in),
    .err_code_o(err_code_o)
  );

  bulk_xact_fsm u_bulk (
    .clock(clock),
    .reset(reset),
    .bulk_active_i(bulk_active),
    .token_in_i(token_in),
    .blk_in_ready_i(blk_in_ready_i),
    .blk_out_ready_i(blk_out_ready_i),
    .usb_sent_i(usb_sent_i),
    .hsk_recv_i(hsk_recv_i),
    .hsk_pid_i(hsk_pid_i),
    .hsk_sent_i(hsk_sent_i),
    .timeout_i(timeout),
    .blk_tvalid_i(blk_tvalid_i),
    .blk_tready_o(blk_tready_o),
    .blk_tlast_i(blk_tlast_i),
    .blk_tkeep_i(blk_tkeep_i),
    .blk_tdata_i(blk_tdata_i),
    .usb_tvalid_o(usb_tvalid_o),
    .usb_tready_i(usb_tready_i),
    .usb_tlast_o(usb_tlast_o),
    .usb_tkeep_o(usb_tkeep_o),
    .usb_tdata_o(usb_tdata_o),
    .usb_tvalid_i(usb_tvalid_i),
    .usb_tready_o(usb_tready_o),
    .usb_tlast_i(usb_tlast_i),
    .usb_tdata_i(usb_tdata_i),
    .blk_tvalid_o(blk_tvalid_o),
    .blk_tready_i(blk_tready_i),
    .blk_tlast_o(blk_tlast_o),
    .blk_tdata_o(blk_tdata_o),
    .blk_start_o(blk_start_o),
    .bulk_done_o(bulk_done),
    .toggle_o(toggle),
    .nak_o(nak),
    .hsk_wait_o(hsk_wait)
  );

  data_toggle #(
    .NUM_ENDP(NUM_ENDP)
  ) u_toggle (
    .clock(clock),
    .reset(reset),
    .tok(tok_if.sink),
    .endp_sel_i(endp_sel),
    .toggle_i(toggle),
    .nak_i(nak),
    .hsk_req_i(hsk_req),
    .usb_tuser_o(usb_tuser_o)
  );

  eop_handshake #(
    .EOP_DELAY(EOP_DELAY)
  ) u_eop (
    .clock(clock),
    .reset(reset),
    .usb_recv_i(usb_recv_i),
    .usb_tvalid_i(usb_tvalid_i),
    .usb_tready_o(usb_tready_o),
    .hsk_wait_i(hsk_wait),
    .hsk_sent_i(hsk_sent_i),
    .hsk_send_o(hsk_send_o),
    .hsk_req_o(hsk_req),
    .rx_event_o(rx_event)
  );

  turnaround_timer #(
    .TURNAROUND(TURNAROUND)
  ) u_timer (
    .clock(clock),
    .reset(reset),
    .tok(tok_if.sink),
    .usb_sent_i(usb_sent_i),
    .rx_event_i(rx_event),
    .hsk_recv_i(hsk_recv_i),
    .timeout_o(timeout),
    .usb_timeout_error_o(usb_timeout_error_o)
  );

  // Device is idle whenever no bulk transaction runs
  assign blk_cycle_o = bulk_active;
  assign usb_device_idle_o = ~bulk_active;
  assign blk_endpt_o = endp_sel;

endmodule

/* sim/usb_bulk_xact_checker.sv */
module usb_bulk_xact_checker (
  input logic clock,
  input logic reset,
  input logic hsk_send_i,
  input logic hsk_sent_i,
  input logic blk_start_i,
  input logic enc_tvalid_i,
  input logic enc_tready_i,
  input logic enc_tlast_i,
  input logic enc_tkeep_i,
  input logic [usb_xact_pkg::BYTE_W-1:0] enc_tdata_i,
  input logic sink_tvalid_i,
  input logic sink_tready_i,
  input logic sink_tlast_i,
  input logic [usb_xact_pkg::BYTE_W-1:0] sink_tdata_i
);

  // Number of assertion failures, read by the testbench at the end
  int fail_count = 0;

  // Handshake request stays up until the encoder has sent it
  hsk_hold: assert property (@(posedge clock) disable iff (reset)
    hsk_send_i && !hsk_sent_i |=> hsk_send_i)
    else begin
      $error("hsk_send_o fell before hsk_sent_i");
      fail_count++;
    end

  // Start strobe is a single cycle
  start_pulse: assert property (@(posedge clock) disable iff (reset)
    blk_start_i |=> !blk_start_i)
    else begin
      $error("blk_start_o high for more than one cycle");
      fail_count++;
    end

  // Encoder beat held steady while stalled
  enc_stable: assert property (@(posedge clock) disable iff (reset)
    enc_tvalid_i && !enc_tready_i |=> enc_tvalid_i && $stable(enc_tdata_i) &&
      $stable(enc_tlast_i) && $stable(enc_tkeep_i))
    else begin
      $error("Encoder beat changed before usb_tready_i");
      fail_count++;
    end

  // User sink beat held while the sink stalls
  sink_stable: assert property (@(posedge clock) disable iff (reset)
    sink_tvalid_i && !sink_tready_i |=> sink_tvalid_i && $stable(sink_tdata_i) &&
      $stable(sink_tlast_i))
    else begin
      $error("User sink beat changed before blk_tready_i");
      fail_count++;
    end

endmodule

bind usb_bulk_xact usb_bulk_xact_checker u_checker (
  .clock(clock),
  .reset(reset),
  .hsk_send_i(hsk_send_o),
  .hsk_sent_i(hsk_sent_i),
  .blk_start_i(blk_start_o),
  .enc_tvalid_i(usb_tvalid_o),
  .enc_tready_i(usb_tready_i),
  .enc_tlast_i(usb_tlast_o),
  .enc_tkeep_i(usb_tkeep_o),
  .enc_tdata_i(usb_tdata_o),
  .sink_tvalid_i(blk_tvalid_o),
  .sink_tready_i(blk_tready_i),
  .sink_tlast_i(blk_tlast_o),
  .sink_tdata_i(blk_tdata_o)
);

/* sim/usb_bulk_xact_tb.sv */
module usb_bulk_xact_tb;

  localparam int EOP_DELAY = 5;
  localparam int TURNAROUND = 40;
  localparam int WAIT_LIMIT = 200;
  localparam logic [6:0] DEV_ADDR = 7'h2a;
  localparam logic [3:0] EP1 = 4'd1;
  localparam logic [3:0] EP2 = 4'd2;

  // Outcome kinds for the reference PID
  localparam int PID_DATA = 0;
  localparam int PID_ACK = 1;
  localparam int PID_NAK = 2;

  typedef struct packed {
    logic [3:0] pid;
    logic keep;
    logic last;
    logic [7:0] data;
  } beat_t;

  logic clock;
  logic reset;
  logic [6:0] usb_addr_i;
  logic usb_timeout_error_o;
  logic usb_device_idle_o;
  usb_xact_pkg::err_code_e err_code_o;
  logic blk_in_ready_i;
  logic blk_out_ready_i;
  logic blk_start_o;
  logic blk_cycle_o;
  logic [3:0] blk_endpt_o;
  logic blk_tvalid_o;
  logic blk_tready_i;
  logic blk_tlast_o;
  logic [7:0] blk_tdata_o;
  logic blk_tvalid_i;
  logic blk_tready_o;
  logic blk_tlast_i;
  logic blk_tkeep_i;
  logic [7:0] blk_tdata_i;
  logic tok_recv_i;
  logic tok_ping_i;
  logic [6:0] tok_addr_i;
  logic [3:0] tok_endp_i;
  usb_xact_pkg::token_pid_e tok_pid_i;
  logic hsk_recv_i;
  usb_xact_pkg::hsk_pid_e hsk_pid_i;
  logic hsk_send_o;
  logic hsk_sent_i;
  logic usb_recv_i;
  logic usb_sent_i;
  logic usb_tvalid_i;
  logic usb_tready_o;
  logic usb_tlast_i;
  logic [7:0] usb_tdata_i;
  logic usb_tvalid_o;
  logic usb_tready_i;
  logic usb_tkeep_o;
  logic usb_tlast_o;
  logic [3:0] usb_tuser_o;
  logic [7:0] usb_tdata_o;

  // Reference model state and scoreboard queues
  logic [15:0] ref_odd;
  logic [31:0] rng_state = 32'h6259f6c9;
  beat_t exp_beats[$];
  logic [8:0] exp_sink[$];
  logic [3:0] exp_hsk[$];
  bit expect_timeout;
  int accepted_count;
  int start_count;
  int cyc;
  int last_rx_cyc;
  int sent_cyc;
  logic prev_hsk;
  logic prev_terr;

  usb_bulk_xact #(
    .EOP_DELAY(EOP_DELAY),
    .TURNAROUND(TURNAROUND)
  ) DUT (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else report_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
  endtask

  // Plain LCG, one step per call
  function automatic logic [31:0] rand_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = rand_next();
    return r[23:16];
  endfunction

  // Packet length 2 to 9
  function automatic int rand_len();
    logic [31:0] r;
    r = rand_next();
    return 2 + int'(r[26:24]);
  endfunction

  // PID field is type in the upper two bits, class in the lower two
  function automatic logic [3:0] expected_pid(input logic [3:0] ep, input int kind);
    case (kind)
      PID_ACK: return {usb_xact_pkg::HSK_ACK, usb_xact_pkg::CLS_HSK};
      PID_NAK: return {usb_xact_pkg::HSK_NAK, usb_xact_pkg::CLS_HSK};
      default: begin
        if (ref_odd[ep]) begin
          return {usb_xact_pkg::DATA1, usb_xact_pkg::CLS_DATA};
        end
        return {usb_xact_pkg::DATA0, usb_xact_pkg::CLS_DATA};
      end
    endcase
  endfunction

  // Called on a falling edge, leaves on the next one
  task automatic send_token(input usb_xact_pkg::token_pid_e pid, input logic [3:0] ep,
                            input logic [6:0] addr);
    tok_recv_i = 1'b1;
    tok_ping_i = 1'b0;
    tok_pid_i = pid;
    tok_endp_i = ep;
    tok_addr_i = addr;
    @(negedge clock);
    tok_recv_i = 1'b0;
  endtask

  task automatic wait_start(input logic [3:0] ep);
    int tries;
    tries = 0;
    while (1) begin
      @(posedge clock);
      if (blk_start_o) begin
        break;
      end
      tries++;
      assert (tries < WAIT_LIMIT) else report_failure("No blk_start_o after an accepted token");
    end
    check_value("blk_endpt_o", blk_endpt_o, ep);
    check_value("err_code_o", err_code_o, usb_xact_pkg::ER_NONE);
    check_value("usb_device_idle_o", usb_device_idle_o, 1'b0);
    @(negedge clock);
  endtask

  task automatic wait_idle();
    int tries;
    tries = 0;
    while (1) begin
      @(posedge clock);
      if (usb_device_idle_o) begin
        break;
      end
      tries++;
      assert (tries < WAIT_LIMIT) else report_failure("Transaction never returned to idle");
    end
    @(negedge clock);
  endtask

  task automatic wait_hsk_send();
    int tries;
    tries = 0;
    while (1) begin
      @(posedge clock);
      if (hsk_send_o) begin
        break;
      end
      tries++;
      assert (tries < WAIT_LIMIT) else report_failure("Handshake request never raised");
    end
    @(negedge clock);
  endtask

  task automatic wait_timeout_flag();
    int tries;
    tries = 0;
    while (1) begin
      @(posedge clock);
      if (usb_timeout_error_o) begin
        break;
      end
      tries++;
      assert (tries < WAIT_LIMIT) else report_failure("Turnaround timeout never flagged");
    end
    @(negedge clock);
  endtask

  // IN transaction, ZDP when the source is not ready
  task automatic bulk_in(input logic [3:0] ep, input bit source_ready, input bit host_ack);
    logic [7:0] bytes[$];
    beat_t beat;
    logic [31:0] r;
    int n;
    int i;
    int tries;
    bit taken;
    n = source_ready ? rand_len() : 1;
    blk_in_ready_i = source_ready;
    for (i = 0; i < n; i++) begin
      bytes.push_back(rand_byte());
      beat.pid = expected_pid(ep, PID_DATA);
      beat.keep = source_ready;
      beat.last = i == n - 1;
      beat.data = source_ready ? bytes[i] : 8'h00;
      exp_beats.push_back(beat);
    end
    send_token(usb_xact_pkg::TOK_IN, ep, DEV_ADDR);
    accepted_count++;
    wait_start(ep);
    for (i = 0; i < n; i++) begin
      if (source_ready) begin
        blk_tvalid_i = 1'b1;
        blk_tdata_i = bytes[i];
        blk_tlast_i = i == n - 1;
        blk_tkeep_i = 1'b1;
      end
      taken = 1'b0;
      tries = 0;
      while (!taken) begin
        // Encoder back-pressure about one cycle in four
        r = rand_next();
        usb_tready_i = r[21:20] != 2'b00;
        @(posedge clock);
        taken = usb_tvalid_o && usb_tready_i;
        // Encoder ready reaches the user source unchanged
        if (source_ready) begin
          check_value("blk_tready_o", blk_tready_o, usb_tready_i);
        end
        @(negedge clock);
        tries++;
        assert (tries < WAIT_LIMIT) else report_failure("Encoder beat never transferred");
      end
    end
    blk_tvalid_i = 1'b0;
    blk_tlast_i = 1'b0;
    usb_tready_i = 1'b0;
    usb_sent_i = 1'b1;
    @(negedge clock);
    usb_sent_i = 1'b0;
    if (host_ack) begin
      hsk_recv_i = 1'b1;
      hsk_pid_i = usb_xact_pkg::HSK_ACK;
      @(negedge clock);
      hsk_recv_i = 1'b0;
      ref_odd[ep] = ~ref_odd[ep];
    end else begin
      // Host stays silent, toggle keeps its value
      expect_timeout = 1'b1;
      wait_timeout_flag();
      expect_timeout = 1'b0;
    end
    wait_idle();
  endtask

  // OUT transaction, data dropped with NAK when the sink is not ready
  task automatic bulk_out(input logic [3:0] ep, input bit sink_ready);
    logic [31:0] r;
    logic [7:0] b;
    int n;
    int i;
    int tries;
    bit taken;
    n = rand_len();
    blk_out_ready_i = sink_ready;
    exp_hsk.push_back(expected_pid(ep, sink_ready ? PID_ACK : PID_NAK));
    send_token(usb_xact_pkg::TOK_OUT, ep, DEV_ADDR);
    accepted_count++;
    wait_start(ep);
    usb_recv_i = 1'b1;
    @(negedge clock);
    usb_recv_i = 1'b0;
    for (i = 0; i < n; i++) begin
      b = rand_byte();
      if (sink_ready) begin
        exp_sink.push_back({i == n - 1, b});
      end
      usb_tvalid_i = 1'b1;
      usb_tdata_i = b;
      usb_tlast_i = i == n - 1;
      taken = 1'b0;
      tries = 0;
      while (!taken) begin
        r = rand_next();
        blk_tready_i = sink_ready && r[19:18] != 2'b00;
        @(posedge clock);
        taken = usb_tready_o;
        @(negedge clock);
        tries++;
        assert (tries < WAIT_LIMIT) else report_failure("Received beat never accepted");
      end
    end
    usb_tvalid_i = 1'b0;
    usb_tlast_i = 1'b0;
    blk_tready_i = 1'b0;
    wait_hsk_send();
    hsk_sent_i = 1'b1;
    @(negedge clock);
    hsk_sent_i = 1'b0;
    if (sink_ready) begin
      ref_odd[ep] = ~ref_odd[ep];
    end
    wait_idle();
  endtask

  // Token that must not start a transaction
  task automatic rejected_token(input usb_xact_pkg::token_pid_e pid, input logic [3:0] ep,
                                input logic [6:0] addr, input usb_xact_pkg::err_code_e exp_err);
    int i;
    send_token(pid, ep, addr);
    for (i = 0; i < 4; i++) begin
      @(posedge clock);
      assert (!blk_cycle_o && usb_device_idle_o)
        else report_failure("Rejected token started a bulk transaction");
    end
    @(negedge clock);
    check_value("err_code_o", err_code_o, exp_err);
  endtask

  // Scoreboard, sampled on the rising edge
  always @(posedge clock) begin
    beat_t exp_beat;
    logic [8:0] exp_byte;
    if (reset) begin
      cyc = 0;
      prev_hsk = 1'b0;
      prev_terr = 1'b0;
    end else begin
      cyc++;
      if (blk_start_o) begin
        start_count++;
      end
      if (usb_sent_i) begin
        sent_cyc = cyc;
      end
      if (usb_tvalid_i && usb_tready_o && usb_tlast_i) begin
        last_rx_cyc = cyc;
      end
      if (usb_tvalid_o && usb_tready_i) begin
        assert (exp_beats.size() > 0) else report_failure("Encoder beat with none expected");
        exp_beat = exp_beats.pop_front();
        check_value("usb_tdata_o", usb_tdata_o, exp_beat.data);
        check_value("usb_tlast_o", usb_tlast_o, exp_beat.last);
        check_value("usb_tkeep_o", usb_tkeep_o, exp_beat.keep);
        check_value("usb_tuser_o", usb_tuser_o, exp_beat.pid);
      end
      // Dropped OUT data queues nothing, so any sink valid there fails
      if (blk_tvalid_o) begin
        assert (exp_sink.size() > 0) else report_failure("User sink beat with none expected");
        if (blk_tready_i) begin
          exp_byte = exp_sink.pop_front();
          check_value("blk_tdata_o", blk_tdata_o, exp_byte[7:0]);
          check_value("blk_tlast_o", blk_tlast_o, exp_byte[8]);
        end
      end
      if (hsk_send_o && !prev_hsk) begin
        assert (exp_hsk.size() > 0) else report_failure("Handshake request with none expected");
        check_value("usb_tuser_o", usb_tuser_o, exp_hsk.pop_front());
        check_value("hsk_send_o delay", cyc - last_rx_cyc, EOP_DELAY + 1);
      end
      if (usb_timeout_error_o && !prev_terr) begin
        assert (expect_timeout) else report_failure("Turnaround timeout while the host answered");
        check_value("usb_timeout_error_o delay", cyc - sent_cyc, TURNAROUND + 1);
      end
      prev_hsk = hsk_send_o;
      prev_terr = usb_timeout_error_o;
    end
  end

  initial begin
    logic [31:0] r;
    logic [3:0] ep;
    int i;
    reset = 1'b1;
    usb_addr_i = DEV_ADDR;
    blk_in_ready_i = 1'b0;
    blk_out_ready_i = 1'b0;
    blk_tready_i = 1'b0;
    blk_tvalid_i = 1'b0;
    blk_tlast_i = 1'b0;
    blk_tkeep_i = 1'b0;
    blk_tdata_i = 8'h00;
    tok_recv_i = 1'b0;
    tok_ping_i = 1'b0;
    tok_addr_i = '0;
    tok_endp_i = '0;
    tok_pid_i = usb_xact_pkg::TOK_OUT;
    hsk_recv_i = 1'b0;
    hsk_pid_i = usb_xact_pkg::HSK_ACK;
    hsk_sent_i = 1'b0;
    usb_recv_i = 1'b0;
    usb_sent_i = 1'b0;
    usb_tvalid_i = 1'b0;
    usb_tlast_i = 1'b0;
    usb_tdata_i = 8'h00;
    usb_tready_i = 1'b0;
    ref_odd = '0;
    expect_timeout = 1'b0;
    accepted_count = 0;
    start_count = 0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // Values right after reset
    check_value("hsk_send_o", hsk_send_o, 1'b0);
    check_value("blk_start_o", blk_start_o, 1'b0);
    check_value("blk_cycle_o", blk_cycle_o, 1'b0);
    check_value("usb_tvalid_o", usb_tvalid_o, 1'b0);
    check_value("blk_tvalid_o", blk_tvalid_o, 1'b0);
    check_value("usb_timeout_error_o", usb_timeout_error_o, 1'b0);
    check_value("err_code_o", err_code_o, usb_xact_pkg::ER_NONE);
    check_value("usb_device_idle_o", usb_device_idle_o, 1'b1);

    // IN with data, DATA0 then DATA1
    bulk_in(EP1, 1'b1, 1'b1);
    bulk_in(EP1, 1'b1, 1'b1);
    // ZDP on the other endpoint
    bulk_in(EP2, 1'b0, 1'b1);
    // OUT accepted, then IN shows the flipped bit
    bulk_out(EP1, 1'b1);
    bulk_in(EP1, 1'b1, 1'b1);
    // OUT dropped with NAK, bit unchanged
    bulk_out(EP2, 1'b0);
    bulk_in(EP2, 1'b1, 1'b1);

    // Token filtering, error code sticks until the next addressed token
    rejected_token(usb_xact_pkg::TOK_SETUP, EP1, DEV_ADDR, usb_xact_pkg::ER_TOKN);
    rejected_token(usb_xact_pkg::TOK_IN, EP1, DEV_ADDR + 7'd1, usb_xact_pkg::ER_TOKN);
    rejected_token(usb_xact_pkg::TOK_IN, 4'd3, DEV_ADDR, usb_xact_pkg::ER_ENDP);
    rejected_token(usb_xact_pkg::TOK_SOF, 4'd0, DEV_ADDR, usb_xact_pkg::ER_TOKN);

    // Silent host, then toggle still as before
    bulk_in(EP1, 1'b1, 1'b0);
    bulk_in(EP1, 1'b1, 1'b1);

    // Mixed random traffic
    for (i = 0; i < 6; i++) begin
      r = rand_next();
      ep = r[28] ? EP1 : EP2;
      if (r[29]) begin
        bulk_in(ep, r[30], 1'b1);
      end else begin
        bulk_out(ep, r[30]);
      end
    end

    check_value("blk_start_o count", start_count, accepted_count);
    assert (exp_beats.size() == 0 && exp_sink.size() == 0 && exp_hsk.size() == 0)
      else report_failure("Expected beats or handshakes never appeared");

    if (DUT.u_checker.fail_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "Protocol assertions failed");
    end
  end

endmodule

/* usb_bulk_xact.f */
design/usb_xact_pkg.sv
design/usb_token_if.sv
design/xact_dispatch.sv
design/bulk_xact_fsm.sv
design/data_toggle.sv
design/eop_handshake.sv
design/turnaround_timer.sv
design/usb_bulk_xact.sv
sim/usb_bulk_xact_checker.sv
sim/usb_bulk_xact_tb.sv
